/* Bender.yml */
package:
  name: conv_pool

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/conv_pool_pkg.sv
      - rtl/line_buffer.sv
      - rtl/conv_window.sv
      - rtl/conv_kernel.sv
      - rtl/max_pool.sv
      - rtl/conv_pool_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/conv_pool_checker.sv
      - test/tb_clock.sv
      - test/tb_conv_pool.sv

/* conv_pool.f */
+incdir+rtl
rtl/conv_pool_pkg.sv
rtl/line_buffer.sv
rtl/conv_window.sv
rtl/conv_kernel.sv
rtl/max_pool.sv
rtl/conv_pool_top.sv
test/conv_pool_checker.sv
test/tb_clock.sv
test/tb_conv_pool.sv

/* rtl/conv_kernel.sv */
module conv_kernel (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         win_valid,
  input  conv_pool_pkg::window_t       win,
  output logic                         win_ready,
  output logic                         feat_valid,
  output conv_pool_pkg::feature_beat_t feat,
  input  logic                         feat_ready
);

  localparam int SUM_W = 13;

  typedef logic signed [SUM_W-1:0] sum_t;

  logic advance;
  logic valid0;
  logic valid1;
  logic last0;
  logic last1;
  sum_t part0 [4];
  sum_t part1 [2];
  sum_t total;

  function automatic sum_t ext(conv_pool_pkg::pixel_t p);
    return sum_t'(p);
  endfunction

  assign advance   = !feat_valid || feat_ready;
  assign win_ready = advance;
  assign total     = part1[0] + part1[1];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid0     <= 1'b0;
      valid1     <= 1'b0;
      feat_valid <= 1'b0;
    end else if (advance) begin
      valid0     <= win_valid;
      valid1     <= valid0;
      feat_valid <= valid1;
    end
  end

  // weights -2 0 1 / 0 1 2 / 1 2 -3
  always_ff @(posedge clk) begin
    if (advance) begin
      part0[0] <= ext(win.tap[2]) - (ext(win.tap[0]) <<< 1);
      part0[1] <= ext(win.tap[4]) + (ext(win.tap[5]) <<< 1);
      part0[2] <= ext(win.tap[6]) + (ext(win.tap[7]) <<< 1);
      part0[3] <= -((ext(win.tap[8]) <<< 1) + ext(win.tap[8]));
      last0    <= win.last;
      part1[0] <= part0[0] + part0[1];
      part1[1] <= part0[2] + part0[3];
      last1    <= last0;
      // relu
      feat.feature <= total[SUM_W-1] ? '0 : conv_pool_pkg::feature_t'(total);
      feat.last    <= last1;
    end
  end

endmodule

/* rtl/conv_pool_cfg.svh */
`ifndef CONV_POOL_CFG_SVH
`define CONV_POOL_CFG_SVH

// side of the square input frame
// must be even and at least 4
`define CONV_POOL_IMG_SIZE 8

// grayscale pixel width
`define CONV_POOL_PIXEL_W 8

// feature width after relu
`define CONV_POOL_FEATURE_W 12

`endif

/* rtl/conv_pool_pkg.sv */
`include "conv_pool_cfg.svh"

package conv_pool_pkg;

  typedef logic [`CONV_POOL_PIXEL_W-1:0] pixel_t;

  typedef logic [`CONV_POOL_FEATURE_W-1:0] feature_t;

  // one pixel per beat, last marks end of frame
  typedef struct packed {
    logic   last;
    pixel_t pixel;
  } pixel_beat_t;

  typedef struct packed {
    logic     last;
    feature_t feature;
  } feature_beat_t;

  // raster order, tap 0 top-left
  typedef struct packed {
    logic         last;
    pixel_t [0:8] tap;
  } window_t;

endpackage

/* rtl/conv_pool_top.sv */
module conv_pool_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  conv_pool_pkg::pixel_beat_t   in_beat,
  output logic                         in_ready,
  output logic                         out_valid,
  output conv_pool_pkg::feature_beat_t out_beat,
  input  logic                         out_ready
);

  logic                         win_valid;
  logic                         win_ready;
  conv_pool_pkg::window_t       win;
  logic                         feat_valid;
  logic                         feat_ready;
  conv_pool_pkg::feature_beat_t feat;

  conv_window i_conv_window (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .win_valid (win_valid),
    .win       (win),
    .win_ready (win_ready)
  );

  conv_kernel i_conv_kernel (
    .clk        (clk),
    .reset      (reset),
    .win_valid  (win_valid),
    .win        (win),
    .win_ready  (win_ready),
    .feat_valid (feat_valid),
    .feat       (feat),
    .feat_ready (feat_ready)
  );

  max_pool i_max_pool (
    .clk        (clk),
    .reset      (reset),
    .feat_valid (feat_valid),
    .feat       (feat),
    .feat_ready (feat_ready),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_ready  (out_ready)
  );

endmodule

/* rtl/conv_window.sv */
`include "conv_pool_cfg.svh"

module conv_window (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  conv_pool_pkg::pixel_beat_t in_beat,
  output logic                       in_ready,
  output logic                       win_valid,
  output conv_pool_pkg::window_t     win,
  input  logic                       win_ready
);

  localparam int SIDE   = `CONV_POOL_IMG_SIZE;
  localparam int PUSHES = SIDE * SIDE + SIDE + 1;
  localparam int CNT_W  = $clog2(PUSHES);
  localparam int POS_W  = $clog2(SIDE);

  logic                         advance;
  logic                         push;
  logic                         flushing;
  logic [CNT_W-1:0]             push_cnt;
  logic [POS_W-1:0]             row;
  logic [POS_W-1:0]             col;
  conv_pool_pkg::pixel_t        new_pix;
  conv_pool_pkg::pixel_t        lb0_out;
  conv_pool_pkg::pixel_t        lb1_out;
  conv_pool_pkg::pixel_t [0:2]  row0;
  conv_pool_pkg::pixel_t [0:2]  row1;
  conv_pool_pkg::pixel_t [0:2]  row2;

  // window register is free or being taken
  assign advance  = !win_valid || win_ready;
  assign in_ready = advance && !flushing;
  assign push     = advance && (flushing || in_valid);
  assign new_pix  = flushing ? '0 : in_beat.pixel;

  // count real and injected pushes per frame
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      push_cnt <= '0;
      flushing <= 1'b0;
    end else if (push) begin
      if (push_cnt == CNT_W'(PUSHES - 1)) begin
        push_cnt <= '0;
        flushing <= 1'b0;
      end else begin
        push_cnt <= push_cnt + 1'b1;
        if (!flushing && in_beat.last) begin
          flushing <= 1'b1;
        end
      end
    end
  end

  // centre position of the window held in the rows
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      win_valid <= 1'b0;
      row       <= '0;
      col       <= '0;
    end else if (advance) begin
      win_valid <= push && (push_cnt > CNT_W'(SIDE));
      if (push && push_cnt == CNT_W'(SIDE + 1)) begin
        row <= '0;
        col <= '0;
      end else if (push && push_cnt > CNT_W'(SIDE + 1)) begin
        if (col == POS_W'(SIDE - 1)) begin
          col <= '0;
          row <= row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  // index 2 is the newest pixel of each row
  always_ff @(posedge clk) begin
    if (push) begin
      row2 <= {row2[1], row2[2], new_pix};
      row1 <= {row1[1], row1[2], lb0_out};
      row0 <= {row0[1], row0[2], lb1_out};
    end
  end

  line_buffer #(
    .data_t (conv_pool_pkg::pixel_t),
    .depth  (SIDE - 3)
  ) i_lb0 (
    .clk   (clk),
    .shift (push),
    .din   (row2[0]),
    .dout  (lb0_out)
  );

  line_buffer #(
    .data_t (conv_pool_pkg::pixel_t),
    .depth  (SIDE - 3)
  ) i_lb1 (
    .clk   (clk),
    .shift (push),
    .din   (row1[0]),
    .dout  (lb1_out)
  );

  // zero padding hides the previous row and frame too
  always_comb begin
    win.tap  = {row0, row1, row2};
    win.last = (row == POS_W'(SIDE - 1)) && (col == POS_W'(SIDE - 1));
    for (int i = 0; i < 3; i++) begin
      if (row == '0) win.tap[i] = '0;
      if (row == POS_W'(SIDE - 1)) win.tap[6 + i] = '0;
      if (col == '0) win.tap[3 * i] = '0;
      if (col == POS_W'(SIDE - 1)) win.tap[3 * i + 2] = '0;
    end
  end

endmodule

/* rtl/line_buffer.sv */
module line_buffer #(
  parameter type data_t = logic [7:0],
  parameter int  depth  = 4
) (
  input  logic  clk,
  input  logic  shift,
  input  data_t din,
  output data_t dout
);

  data_t mem [depth];

  // entry 0 is the newest
  always_ff @(posedge clk) begin
    if (shift) begin
      mem[0] <= din;
      for (int i = 1; i < depth; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  assign dout = mem[depth-1];

endmodule

/* rtl/max_pool.sv */
`include "conv_pool_cfg.svh"

module max_pool (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         feat_valid,
  input  conv_pool_pkg::feature_beat_t feat,
  output logic                         feat_ready,
  output logic                         out_valid,
  output conv_pool_pkg::feature_beat_t out_beat,
  input  logic                         out_ready
);

  localparam int SIDE  = `CONV_POOL_IMG_SIZE;
  localparam int POS_W = $clog2(SIDE);

  logic                    take;
  logic                    produce;
  logic [POS_W-1:0]        row;
  logic [POS_W-1:0]        col;
  conv_pool_pkg::feature_t even_feat;
  conv_pool_pkg::feature_t pair_max;
  conv_pool_pkg::feature_t upper;

  function automatic conv_pool_pkg::feature_t fmax(conv_pool_pkg::feature_t a,
                                                   conv_pool_pkg::feature_t b);
    return (a >= b) ? a : b;
  endfunction

  assign feat_ready = !out_valid || out_ready;
  assign take       = feat_valid && feat_ready;
  assign produce    = take && row[0] && col[0];
  assign pair_max   = fmax(even_feat, feat.feature);

  // even rows store pair maxima, odd rows read them back
  line_buffer #(
    .data_t (conv_pool_pkg::feature_t),
    .depth  (SIDE / 2)
  ) i_pair_buf (
    .clk   (clk),
    .shift (take && col[0]),
    .din   (pair_max),
    .dout  (upper)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      row <= '0;
      col <= '0;
    end else if (take) begin
      if (feat.last) begin
        row <= '0;
        col <= '0;
      end else if (col == POS_W'(SIDE - 1)) begin
        col <= '0;
        row <= (row == POS_W'(SIDE - 1)) ? '0 : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && !col[0]) begin
      even_feat <= feat.feature;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (feat_ready) begin
      out_valid <= produce;
    end
  end

  always_ff @(posedge clk) begin
    if (produce) begin
      out_beat.feature <= fmax(pair_max, upper);
      out_beat.last    <= feat.last;
    end
  end

endmodule

/* test/conv_pool_checker.sv */
`include "conv_pool_cfg.svh"

module conv_pool_checker (
  input logic                         clk,
  input logic                         reset,
  input logic                         in_valid,
  input conv_pool_pkg::pixel_beat_t   in_beat,
  input logic                         in_ready,
  input logic                         out_valid,
  input conv_pool_pkg::feature_beat_t out_beat,
  input logic                         out_ready
);

  localparam int FLUSH = `CONV_POOL_IMG_SIZE + 1;

  // no output while in reset
  assert property (@(posedge clk) reset |-> !out_valid)
    else $error("out_valid high during reset");

  // stalled output beat must hold
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("output beat changed while stalled");

  // flush window after the last pixel
  assert property (@(posedge clk) disable iff (reset)
    in_valid && in_ready && in_beat.last |=> !in_ready [*FLUSH])
    else $error("in_ready high during end of frame flush");

endmodule

bind conv_pool_top conv_pool_checker i_conv_pool_checker (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .in_beat   (in_beat),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_beat  (out_beat),
  .out_ready (out_ready)
);

/* test/conv_pool_tests.mem */
// per frame: 8 words of 8 pixels, column 0 in the top byte
// then 4 words of 4 expected 16-bit pooled values, first in the top half
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
02FD02FD02FD03FC
02FD01FE01FE01FE
02FD01FE01FE01FE
03FC01FE01FE01FE
0000000000000000
0000000000000000
0000000000000000
0000000064000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
000000C800C80000
0000006400000000
0000000000000000
0AC81E28FA003C05
0AC81E28FA003C05
0AC81E28FA003C05
0AC81E28FA003C05
0AC81E28FA003C05
0AC81E28FA003C05
0AC81E28FA003C05
0AC81E28FA003C05
024E00FA031600B4
024E005A02C600B4
024E005A02C600B4
026202DA02C600B4
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF
02FD02FD02FD03FC
02FD01FE01FE01FE
02FD01FE01FE01FE
03FC01FE01FE01FE

/* test/tb_clock.sv */
module tb_clock #(
  parameter int period = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

/* test/tb_conv_pool.sv */
`include "conv_pool_cfg.svh"

module tb_conv_pool;

  localparam int SIDE        = `CONV_POOL_IMG_SIZE;
  localparam int FRAMES      = 4;
  localparam int PIX_FRAME   = SIDE * SIDE;
  localparam int OUT_FRAME   = (SIDE / 2) * (SIDE / 2);
  localparam int WORDS_FRAME = SIDE + OUT_FRAME / 4;
  localparam int TOTAL_OUT   = FRAMES * OUT_FRAME;
  localparam int MAX_CYCLES  = FRAMES * (PIX_FRAME + SIDE + 1) * 4 + 200;

  logic                         clk;
  logic                         reset;
  logic                         in_valid;
  conv_pool_pkg::pixel_beat_t   in_beat;
  logic                         in_ready;
  logic                         out_valid;
  conv_pool_pkg::feature_beat_t out_beat;
  logic                         out_ready;

  logic [63:0] tests_mem [FRAMES * WORDS_FRAME];
  int          errors;
  int          out_cnt;
  int          cycles;

  tb_clock #(.period(20)) i_tb_clock (.clk(clk));

  conv_pool_top i_conv_pool_top (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  function automatic logic [7:0] pixel_at(int frame, int idx);
    logic [63:0] word;
    word = tests_mem[frame * WORDS_FRAME + idx / SIDE];
    return word[63 - 8 * (idx % SIDE) -: 8];
  endfunction

  function automatic logic [15:0] expected_at(int idx);
    logic [63:0] word;
    int          frame;
    int          pos;
    frame = idx / OUT_FRAME;
    pos   = idx % OUT_FRAME;
    word  = tests_mem[frame * WORDS_FRAME + SIDE + pos / 4];
    return word[63 - 16 * (pos % 4) -: 16];
  endfunction

  // stimulus
  initial begin
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    errors    = 0;
    void'($urandom(32'h04a5_a658));
    $readmemh("test/conv_pool_tests.mem", tests_mem);
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int f = 0; f < FRAMES; f++) begin
      for (int i = 0; i < PIX_FRAME; i++) begin
        while ($urandom_range(0, 3) == 0) begin
          in_valid <= 1'b0;
          @(posedge clk);
        end
        in_valid      <= 1'b1;
        in_beat.pixel <= pixel_at(f, i);
        in_beat.last  <= (i == PIX_FRAME - 1);
        do begin
          @(posedge clk);
        end while (!in_ready);
      end
    end
    in_valid <= 1'b0;
    in_beat  <= '0;
  end

  // random back-pressure
  always @(posedge clk) begin
    if (!reset) begin
      out_ready <= ($urandom_range(0, 3) != 0);
    end
  end

  // output monitor checks results in order
  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (out_cnt >= TOTAL_OUT) begin
        errors++;
        $display("an output beat arrived after all expected results");
      end else begin
        check_value("out_beat.feature", 16'(out_beat.feature), expected_at(out_cnt));
        check_value("out_beat.last", 16'(out_beat.last),
                    16'((out_cnt % OUT_FRAME) == OUT_FRAME - 1));
      end
      out_cnt <= out_cnt + 1;
    end
  end

  initial begin
    out_cnt = 0;
  end

  // timeout
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("the run timed out after %0d cycles with %0d of %0d results",
             cycles, out_cnt, TOTAL_OUT);
    $display("errors: %0d", errors);
    $display("Simulation failed");
    $finish;
  end

  // closing
  initial begin
    wait (out_cnt == TOTAL_OUT);
    // catch any extra beat
    repeat (40) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
